/* hw/port_stats_pkg.sv */
//////////////////////////////
// Shared widths, register map and counter indices for the port statistics block
//////////////////////////////

package port_stats_pkg;

    //////////////////////////////
    // Widths

    typedef logic [31:0] reg_word_t;   // One register word
    typedef logic [7:0]  reg_addr_t;   // Word address on the register bus
    typedef logic [31:0] cnt_t;        // One counter value
    typedef logic [7:0]  port_sel_t;   // Select register bits 15:8
    typedef logic [7:0]  cnt_sel_t;    // Select register bits 7:0

    //////////////////////////////
    // Register map

    localparam reg_addr_t ADDR_PARAMS0          = 8'd0; // Data bytes, port count
    localparam reg_addr_t ADDR_PARAMS1          = 8'd1; // MTU
    localparam reg_addr_t ADDR_PORT_ENABLE_CON  = 8'd2;
    localparam reg_addr_t ADDR_PORT_ENABLE_STAT = 8'd3;
    localparam reg_addr_t ADDR_SAMPLE_CON       = 8'd4;
    localparam reg_addr_t ADDR_READ_SEL         = 8'd5;
    localparam reg_addr_t ADDR_READ_DATA        = 8'd6;
    localparam int        NUM_REGS              = 7;    // First undefined address

    //////////////////////////////
    // Snapshot word order per port

    localparam int CNT_PKT      = 0;
    localparam int CNT_BYTE     = 1;
    localparam int CNT_ERR      = 2;
    localparam int CNT_FIFO_OVF = 3;   // Async FIFO overflow
    localparam int CNT_BUF_OVF  = 4;   // Ingress buffer overflow
    localparam int NUM_CNTRS    = 5;

    // One bit per port in a single register word
    localparam int MAX_PORTS = 32;

endpackage

/* hw/port_stats_regs.sv */
//////////////////////////////
// Register file for port control and counter readout
// Single-cycle strobes in, registered read return and error pulse out
//////////////////////////////

module port_stats_regs #(
    parameter int NUM_PORTS  = 4,
    parameter int MTU_BYTES  = 1500,
    parameter int DATA_BYTES = 64
) (
    input  logic                      core_clk_ifc,
    input  logic                      interconnect_sreset_core,

    input  logic                      reg_write,
    input  logic                      reg_read,
    input  port_stats_pkg::reg_addr_t reg_addr,
    input  port_stats_pkg::reg_word_t reg_wdata,
    output port_stats_pkg::reg_word_t reg_rdata,
    output logic                      reg_rvalid,
    output logic                      reg_error,

    input  logic [NUM_PORTS-1:0]      port_connected,
    output logic [NUM_PORTS-1:0]      port_enable,
    output logic [NUM_PORTS-1:0]      sample_req,    // Sample control register
    output port_stats_pkg::port_sel_t port_sel,
    output port_stats_pkg::cnt_sel_t  cnt_sel,
    input  port_stats_pkg::cnt_t      read_data      // From the read mux
);

    //////////////////////////////
    // Constant parameter words

    localparam port_stats_pkg::reg_word_t PARAMS0_WORD =
        {8'd0, 8'(DATA_BYTES), 8'd0, 8'(NUM_PORTS)};
    localparam port_stats_pkg::reg_word_t PARAMS1_WORD = {16'd0, 16'(MTU_BYTES)};

    logic [NUM_PORTS-1:0]      enable_con;    // Port enable control
    logic [NUM_PORTS-1:0]      enable_stat;   // Registered port_connected
    port_stats_pkg::cnt_t      read_data_q;   // Read data register
    port_stats_pkg::reg_word_t rd_word;
    logic                      addr_undef;

    // Zero-extend a per-port vector to a full word
    function automatic port_stats_pkg::reg_word_t ports_to_word(
        input logic [NUM_PORTS-1:0] bits
    );
        logic [port_stats_pkg::MAX_PORTS-1:0] word;
        word = '0;
        word[NUM_PORTS-1:0] = bits;
        return word;
    endfunction

    assign addr_undef = (reg_addr >= port_stats_pkg::NUM_REGS);

    //////////////////////////////
    // Read decode

    always_comb begin
        case (reg_addr)
            port_stats_pkg::ADDR_PARAMS0:          rd_word = PARAMS0_WORD;
            port_stats_pkg::ADDR_PARAMS1:          rd_word = PARAMS1_WORD;
            port_stats_pkg::ADDR_PORT_ENABLE_CON:  rd_word = ports_to_word(enable_con);
            port_stats_pkg::ADDR_PORT_ENABLE_STAT: rd_word = ports_to_word(enable_stat);
            port_stats_pkg::ADDR_SAMPLE_CON:       rd_word = ports_to_word(sample_req);
            port_stats_pkg::ADDR_READ_SEL:         rd_word = {16'd0, port_sel, cnt_sel};
            port_stats_pkg::ADDR_READ_DATA:        rd_word = read_data_q;
            default:                               rd_word = '0; // Undefined reads as zero
        endcase
    end

    //////////////////////////////
    // Control and status registers

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            enable_con  <= '1;            // All ports enabled out of reset
            port_enable <= '1;
            sample_req  <= '0;
            port_sel    <= '0;
            cnt_sel     <= '0;
            enable_stat <= '0;
            read_data_q <= '0;
            reg_rvalid  <= 1'b0;
            reg_error   <= 1'b0;
        end else begin
            port_enable <= enable_con;    // One cycle behind the register
            enable_stat <= port_connected;
            read_data_q <= read_data;
            reg_rvalid  <= reg_read;
            reg_error   <= (reg_read | reg_write) & addr_undef;

            // Only three writable words, the rest ignore writes
            if (reg_write) begin
                case (reg_addr)
                    port_stats_pkg::ADDR_PORT_ENABLE_CON: enable_con <= reg_wdata[NUM_PORTS-1:0];
                    port_stats_pkg::ADDR_SAMPLE_CON:      sample_req <= reg_wdata[NUM_PORTS-1:0];
                    port_stats_pkg::ADDR_READ_SEL: begin
                        port_sel <= reg_wdata[15:8];
                        cnt_sel  <= reg_wdata[7:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read return, contents as they stood before the strobe
    always_ff @(posedge core_clk_ifc) begin
        if (reg_read) begin
            reg_rdata <= rd_word;
        end
    end

endmodule

/* hw/port_counter_sampler.sv */
//////////////////////////////
// One ingress port: overflow event counts and snapshot on a sample request edge
//////////////////////////////

module port_counter_sampler (
    input  logic                   core_clk_ifc,
    input  logic                   interconnect_sreset_core,

    input  logic                   sample_req,   // Rising edge takes a snapshot
    input  port_stats_pkg::cnt_t   pkt_cnt,
    input  port_stats_pkg::cnt_t   byte_cnt,
    input  port_stats_pkg::cnt_t   err_cnt,
    input  logic                   fifo_ovf,     // Async FIFO overflow event
    input  logic                   buf_ovf,      // Ingress buffer overflow event

    output port_stats_pkg::cnt_t [port_stats_pkg::NUM_CNTRS-1:0] snapshot,
    output logic                   cnts_clear    // Clear to the external counters
);

    //////////////////////////////
    // Edge detection

    logic sample_req_d;
    logic fifo_ovf_d;
    logic buf_ovf_d;
    logic sample_rise;
    logic fifo_ovf_rise;
    logic buf_ovf_rise;

    port_stats_pkg::cnt_t fifo_ovf_cnt;   // Events since last snapshot
    port_stats_pkg::cnt_t buf_ovf_cnt;

    assign sample_rise   = sample_req & ~sample_req_d;
    assign fifo_ovf_rise = fifo_ovf & ~fifo_ovf_d;
    assign buf_ovf_rise  = buf_ovf & ~buf_ovf_d;

    //////////////////////////////
    // Counting and snapshot

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            sample_req_d <= 1'b0;
            fifo_ovf_d   <= 1'b0;
            buf_ovf_d    <= 1'b0;
            fifo_ovf_cnt <= '0;
            buf_ovf_cnt  <= '0;
            snapshot     <= '0;
            cnts_clear   <= 1'b0;
        end else begin
            sample_req_d <= sample_req;
            fifo_ovf_d   <= fifo_ovf;
            buf_ovf_d    <= buf_ovf;
            cnts_clear   <= sample_rise;   // Single cycle pulse

            if (sample_rise) begin
                snapshot[port_stats_pkg::CNT_PKT]      <= pkt_cnt;
                snapshot[port_stats_pkg::CNT_BYTE]     <= byte_cnt;
                snapshot[port_stats_pkg::CNT_ERR]      <= err_cnt;
                snapshot[port_stats_pkg::CNT_FIFO_OVF] <= fifo_ovf_cnt;
                snapshot[port_stats_pkg::CNT_BUF_OVF]  <= buf_ovf_cnt;
                // Restart counting, an edge in this cycle is dropped
                fifo_ovf_cnt <= '0;
                buf_ovf_cnt  <= '0;
            end else begin
                if (fifo_ovf_rise) begin
                    fifo_ovf_cnt <= fifo_ovf_cnt + 1'b1;
                end
                if (buf_ovf_rise) begin
                    buf_ovf_cnt <= buf_ovf_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/counter_read_mux.sv */
//////////////////////////////
// Registered pick of one snapshot word by port and counter select
//////////////////////////////

module counter_read_mux #(
    parameter int NUM_PORTS = 4
) (
    input  logic                      core_clk_ifc,
    input  logic                      interconnect_sreset_core,

    input  port_stats_pkg::port_sel_t port_sel,
    input  port_stats_pkg::cnt_sel_t  cnt_sel,
    input  port_stats_pkg::cnt_t [NUM_PORTS-1:0][port_stats_pkg::NUM_CNTRS-1:0] snapshots,
    output port_stats_pkg::cnt_t      read_data
);

    logic sel_valid;   // Both fields in range

    // Out of range selects read back as zero
    assign sel_valid = (int'(port_sel) < NUM_PORTS) &&
                       (int'(cnt_sel) < port_stats_pkg::NUM_CNTRS);

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            read_data <= '0;
        end else if (sel_valid) begin
            read_data <= snapshots[port_sel][cnt_sel];
        end else begin
            read_data <= '0;
        end
    end

endmodule

/* hw/router_port_stats.sv */
//////////////////////////////
// Ingress statistics and port control top, register bus plus per-port counters
//////////////////////////////

module router_port_stats #(
    parameter int NUM_PORTS  = 4,     // 1 to 32
    parameter int MTU_BYTES  = 1500,
    parameter int DATA_BYTES = 64
) (
    input  logic                                  core_clk_ifc,
    input  logic                                  interconnect_sreset_core,

    // Register bus
    input  logic                                  reg_write,
    input  logic                                  reg_read,
    input  port_stats_pkg::reg_addr_t             reg_addr,
    input  port_stats_pkg::reg_word_t             reg_wdata,
    output port_stats_pkg::reg_word_t             reg_rdata,
    output logic                                  reg_rvalid,
    output logic                                  reg_error,

    // Port control
    output logic [NUM_PORTS-1:0]                  port_enable,
    input  logic [NUM_PORTS-1:0]                  port_connected,

    // Counters
    input  port_stats_pkg::cnt_t [NUM_PORTS-1:0]  pkt_cnt,
    input  port_stats_pkg::cnt_t [NUM_PORTS-1:0]  byte_cnt,
    input  port_stats_pkg::cnt_t [NUM_PORTS-1:0]  err_cnt,
    input  logic [NUM_PORTS-1:0]                  fifo_ovf,
    input  logic [NUM_PORTS-1:0]                  buf_ovf,
    output logic [NUM_PORTS-1:0]                  cnts_clear
);

    //////////////////////////////
    // Internal wiring

    logic [NUM_PORTS-1:0]      sample_req;
    port_stats_pkg::port_sel_t port_sel;
    port_stats_pkg::cnt_sel_t  cnt_sel;
    port_stats_pkg::cnt_t      read_data;
    port_stats_pkg::cnt_t [NUM_PORTS-1:0][port_stats_pkg::NUM_CNTRS-1:0] snapshots;

    port_stats_regs #(
        .NUM_PORTS  (NUM_PORTS),
        .MTU_BYTES  (MTU_BYTES),
        .DATA_BYTES (DATA_BYTES)
    ) i_port_stats_regs (
        .core_clk_ifc             (core_clk_ifc),
        .interconnect_sreset_core (interconnect_sreset_core),
        .reg_write                (reg_write),
        .reg_read                 (reg_read),
        .reg_addr                 (reg_addr),
        .reg_wdata                (reg_wdata),
        .reg_rdata                (reg_rdata),
        .reg_rvalid               (reg_rvalid),
        .reg_error                (reg_error),
        .port_connected           (port_connected),
        .port_enable              (port_enable),
        .sample_req               (sample_req),
        .port_sel                 (port_sel),
        .cnt_sel                  (cnt_sel),
        .read_data                (read_data)
    );

    // One sampler per ingress port
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_sampler
        port_counter_sampler i_port_counter_sampler (
            .core_clk_ifc             (core_clk_ifc),
            .interconnect_sreset_core (interconnect_sreset_core),
            .sample_req               (sample_req[i]),
            .pkt_cnt                  (pkt_cnt[i]),
            .byte_cnt                 (byte_cnt[i]),
            .err_cnt                  (err_cnt[i]),
            .fifo_ovf                 (fifo_ovf[i]),
            .buf_ovf                  (buf_ovf[i]),
            .snapshot                 (snapshots[i]),
            .cnts_clear               (cnts_clear[i])
        );
    end

    counter_read_mux #(
        .NUM_PORTS (NUM_PORTS)
    ) i_counter_read_mux (
        .core_clk_ifc             (core_clk_ifc),
        .interconnect_sreset_core (interconnect_sreset_core),
        .port_sel                 (port_sel),
        .cnt_sel                  (cnt_sel),
        .snapshots                (snapshots),
        .read_data                (read_data)
    );

endmodule

/* tb/router_port_stats_tb.sv */
//////////////////////////////
// Testbench for the port statistics block with LFSR driven register and counter traffic
// Responses are compared against a shadow model of the register map and counters
//////////////////////////////

module router_port_stats_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS      = 4;
    localparam int MTU_BYTES      = 1500;
    localparam int DATA_BYTES     = 64;
    localparam int NUM_CNTRS      = port_stats_pkg::NUM_CNTRS;
    localparam int TEST_CYCLES    = 6000;                    // Rough length of all tests
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 2000;  // Generous margin
    localparam int RVALID_WAIT    = 8;                       // Cycles allowed for read return

    logic                                 core_clk_ifc;
    logic                                 interconnect_sreset_core;
    logic                                 reg_write;
    logic                                 reg_read;
    port_stats_pkg::reg_addr_t            reg_addr;
    port_stats_pkg::reg_word_t            reg_wdata;
    port_stats_pkg::reg_word_t            reg_rdata;
    logic                                 reg_rvalid;
    logic                                 reg_error;
    logic [NUM_PORTS-1:0]                 port_enable;
    logic [NUM_PORTS-1:0]                 port_connected;
    port_stats_pkg::cnt_t [NUM_PORTS-1:0] pkt_cnt;
    port_stats_pkg::cnt_t [NUM_PORTS-1:0] byte_cnt;
    port_stats_pkg::cnt_t [NUM_PORTS-1:0] err_cnt;
    logic [NUM_PORTS-1:0]                 fifo_ovf;
    logic [NUM_PORTS-1:0]                 buf_ovf;
    logic [NUM_PORTS-1:0]                 cnts_clear;

    logic [31:0]          lfsr_state;
    int                   cycle_count;

    //////////////////////////////
    // Shadow model state

    logic [NUM_PORTS-1:0] enable_m;
    logic [NUM_PORTS-1:0] sample_m;
    logic [NUM_PORTS-1:0] connected_m;
    logic [15:0]          sel_m;                              // Port and counter select
    port_stats_pkg::cnt_t fifo_cnt_m [NUM_PORTS];             // Events since last snapshot
    port_stats_pkg::cnt_t buf_cnt_m  [NUM_PORTS];
    port_stats_pkg::cnt_t snap_m     [NUM_PORTS][NUM_CNTRS];

    router_port_stats #(
        .NUM_PORTS  (NUM_PORTS),
        .MTU_BYTES  (MTU_BYTES),
        .DATA_BYTES (DATA_BYTES)
    ) i_router_port_stats (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #4 core_clk_ifc = ~core_clk_ifc;   // 8 ns period
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge core_clk_ifc);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, test sequence never finished", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation timeout");
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hD000_0001 : 32'h0);
        end
        return v;
    endfunction

    // Register contents as the register map defines them
    function automatic port_stats_pkg::reg_word_t expected_reg(input port_stats_pkg::reg_addr_t a);
        int p;
        int c;
        p = int'(sel_m[15:8]);
        c = int'(sel_m[7:0]);
        case (a)
            port_stats_pkg::ADDR_PARAMS0:          return 32'((DATA_BYTES << 16) | NUM_PORTS);
            port_stats_pkg::ADDR_PARAMS1:          return 32'(MTU_BYTES);
            port_stats_pkg::ADDR_PORT_ENABLE_CON:  return 32'(enable_m);
            port_stats_pkg::ADDR_PORT_ENABLE_STAT: return 32'(connected_m);
            port_stats_pkg::ADDR_SAMPLE_CON:       return 32'(sample_m);
            port_stats_pkg::ADDR_READ_SEL:         return 32'(sel_m);
            port_stats_pkg::ADDR_READ_DATA:
                return (p < NUM_PORTS && c < NUM_CNTRS) ? snap_m[p][c] : 32'h0;
            default:                               return 32'h0;   // Undefined space
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Check failed in %s", name);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge core_clk_ifc);
    endtask

    //////////////////////////////
    // Register bus access

    task automatic write_reg(input port_stats_pkg::reg_addr_t a, input logic [31:0] d);
        reg_write = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge core_clk_ifc);
        reg_write = 1'b0;
        check_val("write error flag", 32'(a >= 8'd7), 32'(reg_error));
        check_val("no read valid on write", 32'h0, 32'(reg_rvalid));
        case (a)
            port_stats_pkg::ADDR_PORT_ENABLE_CON: enable_m = d[NUM_PORTS-1:0];
            port_stats_pkg::ADDR_SAMPLE_CON: begin
                // Rising bits capture the live counters and restart overflow counts
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (d[p] && !sample_m[p]) begin
                        snap_m[p][port_stats_pkg::CNT_PKT]      = pkt_cnt[p];
                        snap_m[p][port_stats_pkg::CNT_BYTE]     = byte_cnt[p];
                        snap_m[p][port_stats_pkg::CNT_ERR]      = err_cnt[p];
                        snap_m[p][port_stats_pkg::CNT_FIFO_OVF] = fifo_cnt_m[p];
                        snap_m[p][port_stats_pkg::CNT_BUF_OVF]  = buf_cnt_m[p];
                        fifo_cnt_m[p] = '0;
                        buf_cnt_m[p]  = '0;
                    end
                end
                sample_m = d[NUM_PORTS-1:0];
            end
            port_stats_pkg::ADDR_READ_SEL:        sel_m = d[15:0];
            default: ;                            // Read-only or undefined
        endcase
    endtask

    task automatic read_check(input string name, input port_stats_pkg::reg_addr_t a);
        int waited;
        waited    = 0;
        reg_read  = 1'b1;
        reg_addr  = a;
        @(negedge core_clk_ifc);
        reg_read  = 1'b0;
        while (!reg_rvalid) begin
            assert (waited < RVALID_WAIT) else begin
                $display("No read valid within %0d cycles of a read strobe", RVALID_WAIT);
                $display("ERRORS FOUND");
                $fatal(1, "Read return lost");
            end
            @(negedge core_clk_ifc);
            waited++;
        end
        check_val(name, expected_reg(a), reg_rdata);
        check_val({name, " error flag"}, 32'(a >= 8'd7), 32'(reg_error));
    endtask

    //////////////////////////////
    // Test sequence

    initial begin
        logic [31:0]          word;
        logic [NUM_PORTS-1:0] rising;
        logic [7:0]           p_sel;
        logic [7:0]           c_sel;
        int                   fifo_n [NUM_PORTS];
        int                   buf_n  [NUM_PORTS];
        port_stats_pkg::reg_addr_t a;

        lfsr_state               = 32'h306f;
        interconnect_sreset_core = 1'b1;
        reg_write      = 1'b0;
        reg_read       = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        port_connected = '0;
        pkt_cnt        = '0;
        byte_cnt       = '0;
        err_cnt        = '0;
        fifo_ovf       = '0;
        buf_ovf        = '0;
        enable_m       = '1;   // Ports enabled out of reset
        sample_m       = '0;
        connected_m    = '0;
        sel_m          = '0;
        foreach (snap_m[p, c]) snap_m[p][c] = '0;
        foreach (fifo_cnt_m[p]) begin
            fifo_cnt_m[p] = '0;
            buf_cnt_m[p]  = '0;
        end
        repeat (2) @(negedge core_clk_ifc);
        interconnect_sreset_core = 1'b0;
        idle(2);

        // Reset values
        check_val("reset port_enable", 32'hF, 32'(port_enable));
        for (int i = 0; i < port_stats_pkg::NUM_REGS; i++) read_check("reset value", 8'(i));

        // Random writes over the defined map with read-back
        repeat (20) begin
            for (int i = 0; i < port_stats_pkg::NUM_REGS; i++) begin
                write_reg(8'(i), rand_bits(32));
                idle(1);
                check_val("port_enable follows register", 32'(enable_m), 32'(port_enable));
                idle(2);
                read_check("register read-back", 8'(i));
            end
        end

        // Connected status path
        repeat (30) begin
            word           = rand_bits(NUM_PORTS);
            port_connected = word[NUM_PORTS-1:0];
            connected_m    = port_connected;
            idle(2);
            read_check("connected status", port_stats_pkg::ADDR_PORT_ENABLE_STAT);
        end

        // Undefined addresses must leave every register alone
        repeat (40) begin
            a = 8'(rand_bits(8));
            if (a < 8'd7) a = a + 8'd7;
            if (rand_bits(1) == 32'h1) read_check("undefined read", a);
            else write_reg(a, rand_bits(32));
        end
        idle(2);
        for (int i = 0; i < port_stats_pkg::NUM_REGS; i++) read_check("after undefined", 8'(i));

        // Snapshot rounds
        repeat (24) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                pkt_cnt[p]    = rand_bits(32);
                byte_cnt[p]   = rand_bits(32);
                err_cnt[p]    = rand_bits(32);
                fifo_n[p]     = int'(rand_bits(3));
                buf_n[p]      = int'(rand_bits(3));
                fifo_cnt_m[p] = fifo_cnt_m[p] + 32'(fifo_n[p]);
                buf_cnt_m[p]  = buf_cnt_m[p] + 32'(buf_n[p]);
            end
            for (int k = 0; k < 8; k++) begin   // One cycle high and one low per pulse
                for (int p = 0; p < NUM_PORTS; p++) begin
                    fifo_ovf[p] = (k < fifo_n[p]);
                    buf_ovf[p]  = (k < buf_n[p]);
                end
                idle(1);
                fifo_ovf = '0;
                buf_ovf  = '0;
                idle(1);
            end
            word   = rand_bits(NUM_PORTS);
            rising = word[NUM_PORTS-1:0] & ~sample_m;
            write_reg(port_stats_pkg::ADDR_SAMPLE_CON, word);
            check_val("cnts_clear before snapshot", 32'h0, 32'(cnts_clear));
            idle(1);
            check_val("cnts_clear after snapshot", 32'(rising), 32'(cnts_clear));
            idle(1);
            check_val("cnts_clear single cycle", 32'h0, 32'(cnts_clear));
            for (int p = 0; p < NUM_PORTS; p++) begin   // Live counters move on
                pkt_cnt[p]  = rand_bits(32);
                byte_cnt[p] = rand_bits(32);
                err_cnt[p]  = rand_bits(32);
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int c = 0; c < NUM_CNTRS; c++) begin
                    write_reg(port_stats_pkg::ADDR_READ_SEL, 32'((p << 8) | c));
                    idle(2);
                    read_check("snapshot word", port_stats_pkg::ADDR_READ_DATA);
                end
            end
        end

        // Out of range selects
        repeat (30) begin
            p_sel = 8'(rand_bits(8));
            c_sel = 8'(rand_bits(8));
            if (p_sel < 8'(NUM_PORTS) && c_sel < 8'(NUM_CNTRS)) begin
                if (rand_bits(1) == 32'h1) p_sel = p_sel + 8'(NUM_PORTS);
                else c_sel = c_sel + 8'(NUM_CNTRS);
            end
            write_reg(port_stats_pkg::ADDR_READ_SEL, {16'd0, p_sel, c_sel});
            idle(2);
            read_check("select out of range", port_stats_pkg::ADDR_READ_DATA);
            read_check("select read-back", port_stats_pkg::ADDR_READ_SEL);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* router_port_stats.f */
hw/port_stats_pkg.sv
hw/port_stats_regs.sv
hw/port_counter_sampler.sv
hw/counter_read_mux.sv
hw/router_port_stats.sv
tb/router_port_stats_tb.sv

/* Makefile */
# Verilator build and run of the port statistics testbench
TOP = router_port_stats_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f router_port_stats.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
